//--- Bender.yml
package:
  name: operand_fetch

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rfPkg.sv
      - verilog/opPkg.sv
      - verilog/regFile.sv
      - verilog/immExtend.sv
      - verilog/operandSelect.sv
      - verilog/operandFetch.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/operandFetchTb.sv

//--- tests/operandFetchTb.sv
`default_nettype none

`include "operand_defines.svh"

module operandFetchTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MaxWait = 8;
  localparam int FillWidth = `WORD_WIDTH - `IMM_WIDTH;

  logic clk;
  logic rstN;
  logic inValid;
  rfPkg::regSelT read1Sel;
  rfPkg::regSelT read2Sel;
  opPkg::immT imm;
  opPkg::immKindE immKind;
  logic useImm;
  logic write;
  rfPkg::regSelT writeSel;
  rfPkg::wordT writeData;
  rfPkg::wordT opA;
  rfPkg::wordT opB;
  logic outValid;
  logic err;

  int seed;

  // reference register file and the outputs expected after the next edge.
  rfPkg::wordT modelRegs [0:`REG_COUNT-1];
  string expName;
  logic expValid;
  logic expErr;
  rfPkg::wordT expA;
  rfPkg::wordT expB;

  operandFetch uut (
    .clk       (clk),
    .rstN      (rstN),
    .inValid   (inValid),
    .read1Sel  (read1Sel),
    .read2Sel  (read2Sel),
    .imm       (imm),
    .immKind   (immKind),
    .useImm    (useImm),
    .write     (write),
    .writeSel  (writeSel),
    .writeData (writeData),
    .opA       (opA),
    .opB       (opB),
    .outValid  (outValid),
    .err       (err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stopRun(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic compareValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      stopRun("output differs from the reference model");
    end
  endtask

  function automatic rfPkg::wordT widenImm(input opPkg::immT value, input logic [1:0] kind);
    case (kind)
      2'b01: return {{FillWidth{1'b0}}, value};
      2'b10: return {value, {FillWidth{1'b0}}};
      default: return {{FillWidth{value[`IMM_WIDTH-1]}}, value};  // sext and spare code.
    endcase
  endfunction

  // register value as the operand stage should see it, forwarding included.
  function automatic rfPkg::wordT regValue(input rfPkg::regSelT sel, input logic wr,
                                           input rfPkg::regSelT wrSel,
                                           input rfPkg::wordT wrData);
    if (sel == '0) return '0;
    if (wr && (wrSel == sel)) return wrData;
    return modelRegs[sel];
  endfunction

  task automatic checkOutputs();
    compareValue({expName, ".outValid"}, {31'b0, expValid}, {31'b0, outValid});
    compareValue({expName, ".err"}, {31'b0, expErr}, {31'b0, err});
    if (expValid) begin
      compareValue({expName, ".opA"}, expA, opA);
      compareValue({expName, ".opB"}, expB, opB);
    end
  endtask

  // one clock: drive a request, check the previous one, then model this one.
  task automatic applyCycle(input string name, input logic v, input rfPkg::regSelT sel1,
                            input rfPkg::regSelT sel2, input opPkg::immT immIn,
                            input opPkg::immKindE kindIn, input logic useImmIn,
                            input logic wr, input rfPkg::regSelT wrSel,
                            input rfPkg::wordT wrData);
    @(posedge clk);
    inValid <= v;
    read1Sel <= sel1;
    read2Sel <= sel2;
    imm <= immIn;
    immKind <= kindIn;
    useImm <= useImmIn;
    write <= wr;
    writeSel <= wrSel;
    writeData <= wrData;
    @(negedge clk);
    checkOutputs();
    expName = name;
    expValid = v;
    expErr = wr && (wrSel == '0);
    if (v) begin
      expA = regValue(sel1, wr, wrSel, wrData);
      expB = useImmIn ? widenImm(immIn, kindIn) : regValue(sel2, wr, wrSel, wrData);
    end
    if (wr && (wrSel != '0)) begin
      modelRegs[wrSel] = wrData;  // visible from the next cycle.
    end
  endtask

  task automatic applyIdle(input string name);
    applyCycle(name, 1'b0, '0, '0, '0, opPkg::immSext, 1'b0, 1'b0, '0, '0);
  endtask

  task automatic awaitValid(input string name);
    int cycles;
    cycles = 0;
    do begin
      applyIdle(name);
      cycles++;
    end while (outValid !== 1'b1 && cycles < MaxWait);
    if (outValid !== 1'b1) stopRun("timeout: outValid never rose after inValid");
  endtask

  task automatic awaitErr(input string name);
    int cycles;
    cycles = 0;
    do begin
      applyIdle(name);
      cycles++;
    end while (err !== 1'b1 && cycles < MaxWait);
    if (err !== 1'b1) stopRun("timeout: err never rose after a write to register 0");
  endtask

  task automatic randomTraffic(input string name, input int count, input logic immMode);
    logic [31:0] r;
    logic [31:0] d;
    for (int i = 0; i < count; i++) begin
      r = $random(seed);
      d = $random(seed);
      applyCycle(name, immMode | r[0], r[5:1], r[10:6], r[26:11],
                 opPkg::immKindE'(r[28:27]), immMode, r[29], r[31:30] == 2'b00 ? '0 : d[4:0],
                 $random(seed));
    end
  endtask

  initial begin
    logic [31:0] r;
    seed = 43;
    rstN = 1'b0;
    inValid = 1'b1;  // request held in reset must not leak out.
    read1Sel = '0;
    read2Sel = '0;
    imm = '0;
    immKind = opPkg::immSext;
    useImm = 1'b0;
    write = 1'b1;  // register 0 write held in reset.
    writeSel = '0;
    writeData = '0;
    for (int i = 0; i < `REG_COUNT; i++) begin
      modelRegs[i] = '0;
    end
    expName = "reset";
    expValid = 1'b0;
    expErr = 1'b0;
    expA = '0;
    expB = '0;

    repeat (3) @(posedge clk);
    rstN <= 1'b1;
    inValid <= 1'b0;
    write <= 1'b0;
    @(negedge clk);
    compareValue("reset.outValid", 32'd0, {31'b0, outValid});
    compareValue("reset.err", 32'd0, {31'b0, err});

    // every register must read zero out of reset.
    for (int i = 0; i < `REG_COUNT; i++) begin
      applyCycle("resetRead", 1'b1, rfPkg::regSelT'(i), rfPkg::regSelT'(`REG_COUNT - 1 - i),
                 '0, opPkg::immSext, 1'b0, 1'b0, '0, '0);
    end
    awaitValid("resetRead");

    randomTraffic("randomRw", 300, 1'b0);

    // write and read the same register in one cycle.
    for (int i = 0; i < 24; i++) begin
      r = $random(seed);
      if (r[4:0] == '0) r[4:0] = 5'd1;
      applyCycle("forward", 1'b1, r[4:0], i[0] ? r[4:0] : r[9:5], '0, opPkg::immSext,
                 1'b0, 1'b1, r[4:0], $random(seed));
    end

    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < 16; i++) begin
        r = $random(seed);
        r[15] = i[0];  // half of them negative.
        applyCycle("immediate", 1'b1, r[20:16], r[25:21], r[15:0], opPkg::immKindE'(k),
                   1'b1, 1'b0, '0, '0);
      end
    end
    randomTraffic("immRandom", 100, 1'b1);

    applyCycle("zeroWrite", 1'b0, '0, '0, '0, opPkg::immSext, 1'b0, 1'b1, '0, 32'hdeadbeef);
    awaitErr("zeroWrite");
    applyCycle("zeroRead", 1'b1, '0, '0, '0, opPkg::immSext, 1'b0, 1'b0, '0, '0);
    awaitValid("zeroRead");

    randomTraffic("validPattern", 200, 1'b0);
    applyCycle("validPulse", 1'b1, 5'd3, 5'd4, '0, opPkg::immSext, 1'b0, 1'b0, '0, '0);
    awaitValid("validPulse");

    applyIdle("drain");
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verilog
verilog/rfPkg.sv
verilog/opPkg.sv
verilog/regFile.sv
verilog/immExtend.sv
verilog/operandSelect.sv
verilog/operandFetch.sv
tests/operandFetchTb.sv

//--- verilog/immExtend.sv
`default_nettype none

`include "operand_defines.svh"

module immExtend (
  input  wire opPkg::immT     imm,
  input  wire opPkg::immKindE immKind,
  output rfPkg::wordT         immValue
);

  localparam int FillWidth = `WORD_WIDTH - `IMM_WIDTH;

  logic signBit;

  assign signBit = imm[`IMM_WIDTH-1];

  always_comb begin
    case (immKind)
      opPkg::immZext: begin
        immValue = {{FillWidth{1'b0}}, imm};
      end
      opPkg::immUpper: begin
        immValue = {imm, {FillWidth{1'b0}}};  // low half cleared.
      end
      opPkg::immSext: begin
        immValue = {{FillWidth{signBit}}, imm};
      end
      default: begin
        immValue = {{FillWidth{signBit}}, imm};  // unused code, same as sext.
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/opPkg.sv
`default_nettype none

`include "operand_defines.svh"

package opPkg;

  // how the 16-bit field is widened to a word.
  typedef enum logic [1:0] {
    immSext  = 2'b00,  // copy the top bit up.
    immZext  = 2'b01,  // zeros above.
    immUpper = 2'b10   // field in the high half.
  } immKindE;

  // raw immediate as it sits in the instruction.
  typedef logic [`IMM_WIDTH-1:0] immT;

endpackage

`default_nettype wire

//--- verilog/operandFetch.sv
`default_nettype none

module operandFetch (
  input  wire logic           clk,
  input  wire logic           rstN,
  input  wire logic           inValid,
  input  wire rfPkg::regSelT  read1Sel,
  input  wire rfPkg::regSelT  read2Sel,
  input  wire opPkg::immT     imm,
  input  wire opPkg::immKindE immKind,
  input  wire logic           useImm,
  input  wire logic           write,
  input  wire rfPkg::regSelT  writeSel,
  input  wire rfPkg::wordT    writeData,
  output rfPkg::wordT         opA,
  output rfPkg::wordT         opB,
  output logic                outValid,
  output logic                err
);

  rfPkg::wordT read1Data;
  rfPkg::wordT read2Data;
  rfPkg::wordT immValue;

  regFile regFileInst (
    .clk       (clk),
    .rstN      (rstN),
    .read1Sel  (read1Sel),
    .read2Sel  (read2Sel),
    .writeSel  (writeSel),
    .writeData (writeData),
    .write     (write),
    .read1Data (read1Data),
    .read2Data (read2Data),
    .err       (err)
  );

  immExtend immExtendInst (
    .imm      (imm),
    .immKind  (immKind),
    .immValue (immValue)
  );

  // also sees the write-back for forwarding.
  operandSelect operandSelectInst (
    .clk       (clk),
    .rstN      (rstN),
    .inValid   (inValid),
    .useImm    (useImm),
    .read1Sel  (read1Sel),
    .read2Sel  (read2Sel),
    .read1Data (read1Data),
    .read2Data (read2Data),
    .immValue  (immValue),
    .write     (write),
    .writeSel  (writeSel),
    .writeData (writeData),
    .opA       (opA),
    .opB       (opB),
    .outValid  (outValid)
  );

endmodule

`default_nettype wire

//--- verilog/operandSelect.sv
`default_nettype none

module operandSelect (
  input  wire logic          clk,
  input  wire logic          rstN,
  input  wire logic          inValid,
  input  wire logic          useImm,
  input  wire rfPkg::regSelT read1Sel,
  input  wire rfPkg::regSelT read2Sel,
  input  wire rfPkg::wordT   read1Data,
  input  wire rfPkg::wordT   read2Data,
  input  wire rfPkg::wordT   immValue,
  input  wire logic          write,
  input  wire rfPkg::regSelT writeSel,
  input  wire rfPkg::wordT   writeData,
  output rfPkg::wordT        opA,
  output rfPkg::wordT        opB,
  output logic               outValid
);

  logic        writeLive;
  logic        fwd1;
  logic        fwd2;
  rfPkg::wordT regA;
  rfPkg::wordT regB;
  rfPkg::wordT opBNext;

  // write-back that really targets a register.
  assign writeLive = write && (writeSel != '0);

  assign fwd1 = writeLive && (writeSel == read1Sel);
  assign fwd2 = writeLive && (writeSel == read2Sel);

  // The register file only shows a write from the next cycle on, so a
  // same-cycle write-back has to be taken from the bus directly. Index
  // 0 never matches because writeLive excludes it.
  always_comb begin
    if (read1Sel == '0) begin
      regA = '0;
    end else if (fwd1) begin
      regA = writeData;
    end else begin
      regA = read1Data;
    end
  end

  always_comb begin
    if (read2Sel == '0) begin
      regB = '0;
    end else if (fwd2) begin
      regB = writeData;
    end else begin
      regB = read2Data;
    end
  end

  assign opBNext = useImm ? immValue : regB;  // immediate wins.

  // operand registers toward execute.
  always_ff @(posedge clk) begin
    if (inValid) begin
      opA <= regA;
      opB <= opBNext;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= inValid;  // fixed one cycle latency.
    end
  end

endmodule

`default_nettype wire

//--- verilog/operand_defines.svh
`ifndef OPERAND_DEFINES_SVH
`define OPERAND_DEFINES_SVH

// datapath word.
`define WORD_WIDTH 32

// general registers, index 0 reads as zero.
`define REG_COUNT 32
`define SEL_WIDTH 5

// raw immediate field of the instruction.
`define IMM_WIDTH 16

`endif

//--- verilog/regFile.sv
`default_nettype none

`include "operand_defines.svh"

module regFile (
  input  wire logic          clk,
  input  wire logic          rstN,
  input  wire rfPkg::regSelT read1Sel,
  input  wire rfPkg::regSelT read2Sel,
  input  wire rfPkg::regSelT writeSel,
  input  wire rfPkg::wordT   writeData,
  input  wire logic          write,
  output rfPkg::wordT        read1Data,
  output rfPkg::wordT        read2Data,
  output logic               err
);

  // storage for registers 1 to 31 only.
  rfPkg::wordT regs [1:`REG_COUNT-1];

  // full view seen by the read muxes.
  rfPkg::wordT regView [0:`REG_COUNT-1];

  // one enable per register.
  logic [`REG_COUNT-1:0] writeEn;

  always_comb begin
    writeEn = '0;
    writeEn[writeSel] = write;  // one-hot decode.
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int r = 1; r < `REG_COUNT; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int r = 1; r < `REG_COUNT; r++) begin
        if (writeEn[r]) begin
          regs[r] <= writeData;
        end
      end
    end
  end

  always_comb begin
    regView[0] = '0;  // hardwired zero.
    for (int r = 1; r < `REG_COUNT; r++) begin
      regView[r] = regs[r];
    end
  end

  // combinational read ports.
  assign read1Data = regView[read1Sel];
  assign read2Data = regView[read2Sel];

  // A write aimed at register 0 has no storage to land in, so it is
  // dropped here and reported on err for exactly one cycle.
  always_ff @(posedge clk) begin
    if (!rstN) begin
      err <= 1'b0;
    end else begin
      err <= writeEn[0];  // one cycle pulse.
    end
  end

endmodule

`default_nettype wire

//--- verilog/rfPkg.sv
`default_nettype none

`include "operand_defines.svh"

package rfPkg;

  // one register or operand word.
  typedef logic [`WORD_WIDTH-1:0] wordT;

  // register index for read and write ports.
  typedef logic [`SEL_WIDTH-1:0] regSelT;

endpackage

`default_nettype wire
